/* Bender.yml */
package:
  name: ucode_front_end

sources:
  - files:
      - source/ucodePkg.sv
      - source/flowIndexLut.sv
      - source/ucodeRom.sv
      - source/ucodeSequencer.sv
      - source/ucodeFrontEnd.sv
  - target: test
    files:
      - verif/ucodeFrontEndTb.sv

/* compile.f */
source/ucodePkg.sv
source/flowIndexLut.sv
source/ucodeRom.sv
source/ucodeSequencer.sv
source/ucodeFrontEnd.sv
verif/ucodeFrontEndTb.sv

/* source/flowIndexLut.sv */
`timescale 1ns/1ns

module flowIndexLut
(
	input  logic [7:0] opcode,
	input  logic lookupCb,
	output logic [ucodePkg::FlowAddrWidth-1:0] flowStart
);
	import ucodePkg::*;

	always_comb
	begin
		if (lookupCb)
		begin
			// Second byte after a CB prefix
			case (opcode)
				OpcCbBit:
					flowStart = FlowCbBit;
				OpcCbRl:
					flowStart = FlowCbRl;
				default:
					flowStart = FlowCbShort;
			endcase
		end
		else
		begin
			case (opcode)
				OpcNop:
					flowStart = FlowNop;
				OpcDi:
					flowStart = FlowDi;
				OpcLdB:
					flowStart = FlowLdB;
				OpcLdC:
					flowStart = FlowLdC;
				OpcLdA:
					flowStart = FlowLdA;
				OpcIncC:
					flowStart = FlowIncC;
				OpcAddB:
					flowStart = FlowAddB;
				OpcPushBc:
					flowStart = FlowPushBc;
				OpcPopBc:
					flowStart = FlowPopBc;
				OpcJr:
					flowStart = FlowJr;
				OpcJrNz:
					flowStart = FlowJrNz;
				OpcJrZ:
					flowStart = FlowJrZ;
				OpcCb:
					flowStart = FlowMapCb;
				// Everything else runs as a generic one-byte op
				default:
					flowStart = FlowOneByte;
			endcase
		end
	end

endmodule

/* source/ucodeFrontEnd.sv */
`timescale 1ns/1ns

module ucodeFrontEnd
(
	input  logic iClock,
	input  logic rst,
	input  logic [7:0] opcode,
	input  logic opValid,
	input  logic zeroFlag,
	output logic [ucodePkg::UopWidth-1:0] uop,
	output logic uopValid,
	output logic pcInc,
	output logic flagUpdate,
	output logic flowDone,
	output logic ready
);
	import ucodePkg::*;

	logic lookupCb;
	logic [FlowAddrWidth-1:0] flowStart;
	logic [FlowAddrWidth-1:0] flowAddr;
	logic [UopWidth-1:0] uopWord;

	// Opcode to flow start
	flowIndexLut flowIndexLut_i
	(
		.opcode(opcode),
		.lookupCb(lookupCb),
		.flowStart(flowStart)
	);

	ucodeRom ucodeRom_i
	(
		.flowAddr(flowAddr),
		.uopWord(uopWord)
	);

	ucodeSequencer ucodeSequencer_i
	(
		.iClock(iClock),
		.rst(rst),
		.opValid(opValid),
		.zeroFlag(zeroFlag),
		.flowStart(flowStart),
		.uopWord(uopWord),
		.lookupCb(lookupCb),
		.flowAddr(flowAddr),
		.uop(uop),
		.uopValid(uopValid),
		.pcInc(pcInc),
		.flagUpdate(flagUpdate),
		.flowDone(flowDone),
		.ready(ready)
	);

endmodule

/* source/ucodePkg.sv */
package ucodePkg;

	////////////////////////////////////////
	// Micro-operation word layout
	////////////////////////////////////////

	localparam int CtlWidth = 4;
	localparam int OpWidth = 5;
	localparam int ArgWidth = 5;
	localparam int UopWidth = CtlWidth + OpWidth + ArgWidth;
	localparam int FlowAddrWidth = 6;

	// Flow control, top field of the word
	localparam logic [CtlWidth-1:0] CtlOp = 4'd0;
	localparam logic [CtlWidth-1:0] CtlInc = 4'd1;
	localparam logic [CtlWidth-1:0] CtlEof = 4'd2;
	localparam logic [CtlWidth-1:0] CtlIncEof = 4'd3;
	localparam logic [CtlWidth-1:0] CtlEofFu = 4'd4;
	localparam logic [CtlWidth-1:0] CtlIncEofFu = 4'd5;
	localparam logic [CtlWidth-1:0] CtlUpdateFlags = 4'd6;
	localparam logic [CtlWidth-1:0] CtlIncEofZ = 4'd7;
	localparam logic [CtlWidth-1:0] CtlIncEofNz = 4'd8;

	// Operations
	localparam logic [OpWidth-1:0] OpNop = 5'd0;
	localparam logic [OpWidth-1:0] OpSma = 5'd1;
	localparam logic [OpWidth-1:0] OpSrm = 5'd2;
	localparam logic [OpWidth-1:0] OpSmw = 5'd3;
	localparam logic [OpWidth-1:0] OpInc16 = 5'd4;
	localparam logic [OpWidth-1:0] OpDec16 = 5'd5;
	localparam logic [OpWidth-1:0] OpSx16r = 5'd6;
	localparam logic [OpWidth-1:0] OpSrx16 = 5'd7;
	localparam logic [OpWidth-1:0] OpAddx16 = 5'd8;
	localparam logic [OpWidth-1:0] OpSubx16 = 5'd9;
	localparam logic [OpWidth-1:0] OpSpc = 5'd10;
	localparam logic [OpWidth-1:0] OpShl = 5'd11;
	localparam logic [OpWidth-1:0] OpBit = 5'd12;
	localparam logic [OpWidth-1:0] OpCeti = 5'd13;
	localparam logic [OpWidth-1:0] OpZ80OneByte = 5'd14;
	localparam logic [OpWidth-1:0] OpJcb = 5'd15;

	// Operands
	localparam logic [ArgWidth-1:0] RegNull = 5'd0;
	localparam logic [ArgWidth-1:0] RegA = 5'd1;
	localparam logic [ArgWidth-1:0] RegB = 5'd2;
	localparam logic [ArgWidth-1:0] RegC = 5'd3;
	localparam logic [ArgWidth-1:0] RegH = 5'd4;
	localparam logic [ArgWidth-1:0] RegL = 5'd5;
	localparam logic [ArgWidth-1:0] RegPc = 5'd6;
	localparam logic [ArgWidth-1:0] RegSp = 5'd7;
	localparam logic [ArgWidth-1:0] RegX8 = 5'd8;
	localparam logic [ArgWidth-1:0] RegX16 = 5'd9;

	////////////////////////////////////////
	// Flow start addresses in the ROM
	////////////////////////////////////////

	localparam logic [FlowAddrWidth-1:0] FlowOneByte = 6'd0;
	localparam logic [FlowAddrWidth-1:0] FlowNop = 6'd2;
	localparam logic [FlowAddrWidth-1:0] FlowDi = 6'd3;
	localparam logic [FlowAddrWidth-1:0] FlowLdB = 6'd4;
	localparam logic [FlowAddrWidth-1:0] FlowLdC = 6'd7;
	localparam logic [FlowAddrWidth-1:0] FlowLdA = 6'd10;
	localparam logic [FlowAddrWidth-1:0] FlowIncC = 6'd13;
	localparam logic [FlowAddrWidth-1:0] FlowAddB = 6'd14;
	localparam logic [FlowAddrWidth-1:0] FlowPushBc = 6'd17;
	localparam logic [FlowAddrWidth-1:0] FlowPopBc = 6'd23;
	localparam logic [FlowAddrWidth-1:0] FlowJr = 6'd29;
	localparam logic [FlowAddrWidth-1:0] FlowJrNz = 6'd35;
	localparam logic [FlowAddrWidth-1:0] FlowJrZ = 6'd41;
	localparam logic [FlowAddrWidth-1:0] FlowMapCb = 6'd47;
	// CB table
	localparam logic [FlowAddrWidth-1:0] FlowCbShort = 6'd50;
	localparam logic [FlowAddrWidth-1:0] FlowCbBit = 6'd51;
	localparam logic [FlowAddrWidth-1:0] FlowCbRl = 6'd52;

	// Opcode bytes
	localparam logic [7:0] OpcNop = 8'h00;
	localparam logic [7:0] OpcDi = 8'hF3;
	localparam logic [7:0] OpcLdB = 8'h06;
	localparam logic [7:0] OpcLdC = 8'h0E;
	localparam logic [7:0] OpcLdA = 8'h3E;
	localparam logic [7:0] OpcIncC = 8'h0C;
	localparam logic [7:0] OpcAddB = 8'h80;
	localparam logic [7:0] OpcPushBc = 8'hC5;
	localparam logic [7:0] OpcPopBc = 8'hC1;
	localparam logic [7:0] OpcJr = 8'h18;
	localparam logic [7:0] OpcJrNz = 8'h20;
	localparam logic [7:0] OpcJrZ = 8'h28;
	localparam logic [7:0] OpcCb = 8'hCB;
	localparam logic [7:0] OpcCbBit = 8'h7C;
	localparam logic [7:0] OpcCbRl = 8'h11;

endpackage

/* source/ucodeRom.sv */
`timescale 1ns/1ns

module ucodeRom
(
	input  logic [ucodePkg::FlowAddrWidth-1:0] flowAddr,
	output logic [ucodePkg::UopWidth-1:0] uopWord
);
	import ucodePkg::*;

	always_comb
	begin
		case (flowAddr)
			////////////////////////////////////////
			// Main table
			////////////////////////////////////////

			// Generic one-byte op
			FlowOneByte:          uopWord = {CtlUpdateFlags, OpZ80OneByte, RegA};
			FlowOneByte + 6'd1:   uopWord = {CtlIncEof, OpNop, RegNull};

			FlowNop:              uopWord = {CtlIncEof, OpNop, RegNull};

			// Interrupts off
			FlowDi:               uopWord = {CtlIncEof, OpCeti, RegNull};

			// LD r,n reads the literal after the opcode
			FlowLdB:              uopWord = {CtlInc, OpSma, RegPc};
			FlowLdB + 6'd1:       uopWord = {CtlInc, OpNop, RegNull};
			FlowLdB + 6'd2:       uopWord = {CtlEof, OpSrm, RegB};

			FlowLdC:              uopWord = {CtlInc, OpSma, RegPc};
			FlowLdC + 6'd1:       uopWord = {CtlInc, OpNop, RegNull};
			FlowLdC + 6'd2:       uopWord = {CtlEof, OpSrm, RegC};

			FlowLdA:              uopWord = {CtlInc, OpSma, RegPc};
			FlowLdA + 6'd1:       uopWord = {CtlInc, OpNop, RegNull};
			FlowLdA + 6'd2:       uopWord = {CtlEof, OpSrm, RegA};

			FlowIncC:             uopWord = {CtlIncEofFu, OpInc16, RegC};

			// A goes through x16 for the add
			FlowAddB:             uopWord = {CtlOp, OpSx16r, RegA};
			FlowAddB + 6'd1:      uopWord = {CtlUpdateFlags, OpAddx16, RegB};
			FlowAddB + 6'd2:      uopWord = {CtlIncEof, OpSrx16, RegA};

			// Push B then C, SP pre-decremented
			FlowPushBc:           uopWord = {CtlOp, OpDec16, RegSp};
			FlowPushBc + 6'd1:    uopWord = {CtlOp, OpSma, RegSp};
			FlowPushBc + 6'd2:    uopWord = {CtlOp, OpSmw, RegB};
			FlowPushBc + 6'd3:    uopWord = {CtlOp, OpDec16, RegSp};
			FlowPushBc + 6'd4:    uopWord = {CtlOp, OpSmw, RegC};
			FlowPushBc + 6'd5:    uopWord = {CtlIncEof, OpSma, RegPc};

			FlowPopBc:            uopWord = {CtlOp, OpSma, RegSp};
			FlowPopBc + 6'd1:     uopWord = {CtlOp, OpInc16, RegSp};
			FlowPopBc + 6'd2:     uopWord = {CtlOp, OpSrm, RegC};
			FlowPopBc + 6'd3:     uopWord = {CtlOp, OpSrm, RegB};
			FlowPopBc + 6'd4:     uopWord = {CtlInc, OpInc16, RegSp};
			FlowPopBc + 6'd5:     uopWord = {CtlEof, OpSma, RegPc};

			// Relative jump, offset sign extended into x16
			FlowJr:               uopWord = {CtlInc, OpSma, RegPc};
			FlowJr + 6'd1:        uopWord = {CtlOp, OpNop, RegNull};
			FlowJr + 6'd2:        uopWord = {CtlInc, OpSrm, RegX8};
			FlowJr + 6'd3:        uopWord = {CtlOp, OpSx16r, RegPc};
			FlowJr + 6'd4:        uopWord = {CtlOp, OpAddx16, RegX8};
			FlowJr + 6'd5:        uopWord = {CtlEof, OpSpc, RegX16};

			// Falls out at the third word when Z is set
			FlowJrNz:             uopWord = {CtlInc, OpSma, RegPc};
			FlowJrNz + 6'd1:      uopWord = {CtlOp, OpNop, RegNull};
			FlowJrNz + 6'd2:      uopWord = {CtlIncEofZ, OpSrm, RegX8};
			FlowJrNz + 6'd3:      uopWord = {CtlOp, OpSx16r, RegPc};
			FlowJrNz + 6'd4:      uopWord = {CtlOp, OpAddx16, RegX8};
			FlowJrNz + 6'd5:      uopWord = {CtlEof, OpSpc, RegX16};

			FlowJrZ:              uopWord = {CtlInc, OpSma, RegPc};
			FlowJrZ + 6'd1:       uopWord = {CtlOp, OpNop, RegNull};
			FlowJrZ + 6'd2:       uopWord = {CtlIncEofNz, OpSrm, RegX8};
			FlowJrZ + 6'd3:       uopWord = {CtlOp, OpSx16r, RegPc};
			FlowJrZ + 6'd4:       uopWord = {CtlOp, OpAddx16, RegX8};
			FlowJrZ + 6'd5:       uopWord = {CtlEof, OpSpc, RegX16};

			// CB prefix, last word hands over to the CB table
			FlowMapCb:            uopWord = {CtlInc, OpSma, RegPc};
			FlowMapCb + 6'd1:     uopWord = {CtlOp, OpNop, RegNull};
			FlowMapCb + 6'd2:     uopWord = {CtlInc, OpJcb, RegNull};

			////////////////////////////////////////
			// CB table
			////////////////////////////////////////

			FlowCbShort:          uopWord = {CtlIncEofFu, OpZ80OneByte, RegNull};
			FlowCbBit:            uopWord = {CtlEofFu, OpBit, RegH};
			FlowCbRl:             uopWord = {CtlEofFu, OpShl, RegC};

			default:
				uopWord = {CtlOp, OpNop, RegNull};
		endcase
	end

endmodule

/* source/ucodeSequencer.sv */
`timescale 1ns/1ns

module ucodeSequencer
(
	input  logic iClock,
	input  logic rst,
	input  logic opValid,
	input  logic zeroFlag,
	input  logic [ucodePkg::FlowAddrWidth-1:0] flowStart,
	input  logic [ucodePkg::UopWidth-1:0] uopWord,
	output logic lookupCb,
	output logic [ucodePkg::FlowAddrWidth-1:0] flowAddr,
	output logic [ucodePkg::UopWidth-1:0] uop,
	output logic uopValid,
	output logic pcInc,
	output logic flagUpdate,
	output logic flowDone,
	output logic ready
);
	import ucodePkg::*;

	logic busy;
	logic cbWait;
	logic [FlowAddrWidth-1:0] upc;
	logic [CtlWidth-1:0] ctl;
	logic [OpWidth-1:0] op;
	logic accept;
	logic ctlInc;
	logic ctlFu;
	logic ctlEnd;
	logic jumpCb;

	assign ctl = uopWord[UopWidth-1 -: CtlWidth];
	assign op = uopWord[UopWidth-CtlWidth-1 -: OpWidth];
	assign jumpCb = (op == OpJcb);
	assign accept = opValid && ready;

	// Control field decode
	always_comb
	begin
		ctlInc = 1'b0;
		ctlFu = 1'b0;
		ctlEnd = 1'b0;
		case (ctl)
			CtlInc:
				ctlInc = 1'b1;
			CtlEof:
				ctlEnd = 1'b1;
			CtlIncEof:
			begin
				ctlInc = 1'b1;
				ctlEnd = 1'b1;
			end
			CtlEofFu:
			begin
				ctlFu = 1'b1;
				ctlEnd = 1'b1;
			end
			CtlIncEofFu:
			begin
				ctlInc = 1'b1;
				ctlFu = 1'b1;
				ctlEnd = 1'b1;
			end
			CtlUpdateFlags:
				ctlFu = 1'b1;
			// Conditional exits on the zero flag
			CtlIncEofZ:
			begin
				ctlInc = 1'b1;
				ctlEnd = zeroFlag;
			end
			CtlIncEofNz:
			begin
				ctlInc = 1'b1;
				ctlEnd = !zeroFlag;
			end
			default:
			begin
				ctlInc = 1'b0;
			end
		endcase
	end

	assign flowAddr = upc;
	assign uop = uopWord;
	assign uopValid = busy;
	assign pcInc = busy && ctlInc;
	assign flagUpdate = busy && ctlFu;
	assign flowDone = busy && ctlEnd && !jumpCb;
	assign ready = !busy;
	assign lookupCb = cbWait;

	////////////////////////////////////////
	// Micro-program counter
	////////////////////////////////////////

	always_ff @(posedge iClock)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cbWait <= 1'b0;
			upc <= '0;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			cbWait <= 1'b0;
			upc <= flowStart;
		end
		else if (busy)
		begin
			// Prefix done, wait for the CB byte
			if (jumpCb)
			begin
				busy <= 1'b0;
				cbWait <= 1'b1;
			end
			else if (ctlEnd)
				busy <= 1'b0;
			else
				upc <= upc + 6'd1;
		end
	end

	// A finished flow leaves the sequencer idle and outside the CB wait
	assert property (@(posedge iClock) disable iff (rst)
		flowDone |=> ready && !lookupCb);

	// The CB wait only exists between flows
	assert property (@(posedge iClock) disable iff (rst) lookupCb |-> ready);

	// A flow only starts from an accepted byte
	assert property (@(posedge iClock) disable iff (rst)
		$rose(uopValid) |-> $past(opValid && ready));

endmodule

/* verif/ucodeFrontEndTb.sv */
`timescale 1ns/1ns

module ucodeFrontEndTb;
	import ucodePkg::*;

	localparam int NumOps = 200;
	localparam int ResetCycles = 10;
	// Accept, six words and the idle cycle before the next accept
	localparam int MaxFlowCycles = 7;
	// Margin brings the limit to 2500 cycles
	localparam int Margin = 1090;
	localparam int CycleLimit = NumOps * MaxFlowCycles + ResetCycles + Margin;

	logic iClock;
	logic rst;
	logic [7:0] opcode;
	logic opValid;
	logic zeroFlag;
	logic [UopWidth-1:0] uop;
	logic uopValid;
	logic pcInc;
	logic flagUpdate;
	logic flowDone;
	logic ready;

	logic [15:0] lfsrState;
	int errorCount;
	int cycleCount;
	int flowsSeen;

	// Accepted bytes waiting for their flow
	logic [7:0] codeQ [$];
	logic cbQ [$];
	logic zeroQ [$];

	logic [7:0] keptOpcodes [0:12] = '{OpcNop, OpcDi, OpcLdB, OpcLdC, OpcLdA, OpcIncC,
		OpcAddB, OpcPushBc, OpcPopBc, OpcJr, OpcJrNz, OpcJrZ, OpcCb};

	ucodeFrontEnd ucodeFrontEnd_i
	(
		.iClock(iClock),
		.rst(rst),
		.opcode(opcode),
		.opValid(opValid),
		.zeroFlag(zeroFlag),
		.uop(uop),
		.uopValid(uopValid),
		.pcInc(pcInc),
		.flagUpdate(flagUpdate),
		.flowDone(flowDone),
		.ready(ready)
	);

	initial
	begin
		iClock = 1'b0;
		forever #2 iClock = ~iClock;
	end

	////////////////////////////////////////
	// Random numbers and expected values
	////////////////////////////////////////

	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		else
			return state >> 1;
	endfunction

	// One LFSR step per bit
	task automatic drawBits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[6:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// Word count, strobe counts, CB wait and last op field of one flow
	function automatic void expectFlow(input logic [7:0] code, input logic cbByte,
		input logic z, output int words, output int incs, output int fus,
		output logic waitCb, output logic [OpWidth-1:0] lastOp);
		words = 1;
		incs = 1;
		fus = 0;
		waitCb = 1'b0;
		lastOp = OpNop;
		if (cbByte)
		begin
			fus = 1;
			case (code)
				OpcCbBit:
				begin
					incs = 0;
					lastOp = OpBit;
				end
				OpcCbRl:
				begin
					incs = 0;
					lastOp = OpShl;
				end
				default:
					lastOp = OpZ80OneByte;
			endcase
		end
		else
		begin
			case (code)
				OpcNop:
					lastOp = OpNop;
				OpcDi:
					lastOp = OpCeti;
				OpcLdB, OpcLdC, OpcLdA:
				begin
					words = 3;
					incs = 2;
					lastOp = OpSrm;
				end
				OpcIncC:
				begin
					fus = 1;
					lastOp = OpInc16;
				end
				OpcAddB:
				begin
					words = 3;
					fus = 1;
					lastOp = OpSrx16;
				end
				OpcPushBc, OpcPopBc:
				begin
					words = 6;
					lastOp = OpSma;
				end
				OpcJr:
				begin
					words = 6;
					incs = 2;
					lastOp = OpSpc;
				end
				// Conditional jumps leave at the third word
				OpcJrNz:
				begin
					words = z ? 3 : 6;
					incs = 2;
					lastOp = z ? OpSrm : OpSpc;
				end
				OpcJrZ:
				begin
					words = z ? 6 : 3;
					incs = 2;
					lastOp = z ? OpSpc : OpSrm;
				end
				OpcCb:
				begin
					words = 3;
					incs = 2;
					waitCb = 1'b1;
					lastOp = OpJcb;
				end
				default:
				begin
					words = 2;
					fus = 1;
				end
			endcase
		end
	endfunction

	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("mismatch at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual);
			errorCount++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic pickOpcode(input logic cbByte, output logic [7:0] code);
		logic [7:0] bits;
		drawBits(2, bits);
		if (cbByte)
		begin
			if (bits[1:0] == 2'd0)
				code = OpcCbBit;
			else if (bits[1:0] == 2'd1)
				code = OpcCbRl;
			else
				drawBits(8, code);
		end
		else if (bits[1:0] != 2'd3)
		begin
			drawBits(4, bits);
			code = keptOpcodes[bits % 13];
		end
		else
			drawBits(8, code);
	endtask

	// Called a little after a rising edge
	task automatic sendOpcode(input logic [7:0] code, input logic cbByte, input logic z,
		input logic stray);
		logic [7:0] junk;
		while (!ready)
		begin
			@(posedge iClock);
			#1;
		end
		codeQ.push_back(code);
		cbQ.push_back(cbByte);
		zeroQ.push_back(z);
		opcode = code;
		zeroFlag = z;
		opValid = 1'b1;
		@(posedge iClock);
		#1;
		opValid = 1'b0;
		// Busy now, so this strobe must be dropped
		if (stray)
		begin
			drawBits(8, junk);
			opcode = junk;
			opValid = 1'b1;
			@(posedge iClock);
			#1;
			opValid = 1'b0;
		end
	endtask

	logic [7:0] nextCode;
	logic [7:0] drawn;
	logic nextZero;
	logic cbPending;
	logic nextWait;
	int dummyWords;
	int dummyIncs;
	int dummyFus;
	logic [OpWidth-1:0] dummyOp;

	initial
	begin
		rst = 1'b1;
		opcode = 8'h00;
		opValid = 1'b0;
		zeroFlag = 1'b0;
		lfsrState = 16'd20;
		errorCount = 0;
		cbPending = 1'b0;
		repeat (ResetCycles) @(posedge iClock);
		#1;
		rst = 1'b0;
		@(negedge iClock);
		checkValue("ready", 1, ready);
		checkValue("uopValid", 0, uopValid);
		@(posedge iClock);
		#1;
		for (int n = 0; n < NumOps; n++)
		begin
			pickOpcode(cbPending, nextCode);
			drawBits(1, drawn);
			nextZero = drawn[0];
			expectFlow(nextCode, cbPending, nextZero, dummyWords, dummyIncs, dummyFus,
				nextWait, dummyOp);
			drawBits(2, drawn);
			sendOpcode(nextCode, cbPending, nextZero, drawn[1:0] == 2'd0);
			cbPending = nextWait;
		end
		// Let the last flow drain
		repeat (MaxFlowCycles + 2) @(posedge iClock);
		@(negedge iClock);
		checkValue("flows", NumOps, flowsSeen);
		checkValue("pending flows", 0, codeQ.size());
		$display("Errors: %0d, flows checked: %0d", errorCount, flowsSeen);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////
	// Monitor
	////////////////////////////////////////

	logic inFlow = 1'b0;
	logic [7:0] curCode;
	logic curCb;
	logic curZero;
	int wordCount;
	int incCount;
	int fuCount;
	int doneCount;
	logic [OpWidth-1:0] lastOp;
	int expWords;
	int expIncs;
	int expFus;
	logic expWait;
	logic [OpWidth-1:0] expOp;

	initial
		flowsSeen = 0;

	always @(negedge iClock)
	begin
		if (!rst)
		begin
			if (uopValid)
			begin
				if (!inFlow)
				begin
					inFlow = 1'b1;
					wordCount = 0;
					incCount = 0;
					fuCount = 0;
					doneCount = 0;
					if (codeQ.size() == 0)
					begin
						$display("Error at %0t ns: a flow started with no accepted opcode",
							$time);
						errorCount++;
						curCode = 8'h00;
						curCb = 1'b0;
						curZero = 1'b0;
					end
					else
					begin
						curCode = codeQ.pop_front();
						curCb = cbQ.pop_front();
						curZero = zeroQ.pop_front();
					end
				end
				if (doneCount != 0)
				begin
					$display("Error at %0t ns: words kept coming after flowDone, opcode %h",
						$time, curCode);
					errorCount++;
				end
				checkValue("ready", 0, ready);
				wordCount++;
				incCount += pcInc;
				fuCount += flagUpdate;
				doneCount += flowDone;
				lastOp = uop[UopWidth-CtlWidth-1 -: OpWidth];
			end
			else
			begin
				checkValue("pcInc", 0, pcInc);
				checkValue("flagUpdate", 0, flagUpdate);
				checkValue("flowDone", 0, flowDone);
				if (inFlow)
				begin
					inFlow = 1'b0;
					flowsSeen++;
					expectFlow(curCode, curCb, curZero, expWords, expIncs, expFus,
						expWait, expOp);
					checkValue("uopValid", expWords, wordCount);
					checkValue("pcInc", expIncs, incCount);
					checkValue("flagUpdate", expFus, fuCount);
					checkValue("flowDone", expWait ? 0 : 1, doneCount);
					checkValue("uop", expOp, lastOp);
					checkValue("ready", 1, ready);
				end
			end
		end
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < CycleLimit)
		begin
			@(posedge iClock);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
		$display("Errors: %0d, flows checked: %0d", errorCount, flowsSeen);
		$display("Finished with errors");
		$finish;
	end

endmodule
